//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

  // widths
  localparam int xlen       = 32;
  localparam int ilen       = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs   = 32;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [ilen-1:0]       inst_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  localparam word_t pc_step  = 32'd4;
  localparam word_t reset_pc = 32'h0000_0000;
  localparam inst_t nop_inst = 32'h0000_0013; // addi x0, x0, 0

  // major opcodes
  localparam logic [6:0] opc_op     = 7'b011_0011;
  localparam logic [6:0] opc_op_imm = 7'b001_0011;
  localparam logic [6:0] opc_lui    = 7'b011_0111;

  // funct3, shared by the register and immediate forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [6:0] alt_funct7 = 7'b010_0000; // sub, sra, srai

  // field positions, lsb and width
  localparam int opc_lsb    = 0;
  localparam int opc_w      = 7;
  localparam int rd_lsb     = 7;
  localparam int funct3_lsb = 12;
  localparam int funct3_w   = 3;
  localparam int rs1_lsb    = 15;
  localparam int rs2_lsb    = 20;
  localparam int funct7_lsb = 25;
  localparam int funct7_w   = 7;
  localparam int imm_i_lsb  = 20;
  localparam int imm_i_w    = 12;
  localparam int imm_u_lsb  = 12;
  localparam int imm_u_w    = 20;

endpackage

//--- source/core_ctrl_pkg.sv
package core_ctrl_pkg;

  // alu functions, pass_b forwards operand b untouched
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_fn_e;

  // second alu operand
  typedef enum logic {
    op_b_rs2,
    op_b_imm
  } op_b_sel_e;

  // first alu operand, zero is taken by lui
  typedef enum logic {
    op_a_rs1,
    op_a_zero
  } op_a_sel_e;

endpackage

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import rv_isa_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  fetch_en,
  input  inst_t imem_data,
  output word_t imem_addr,
  output logic  if_valid,
  output word_t if_pc,
  output inst_t if_inst
);

  word_t pc;

  assign imem_addr = pc; // memory answers within the cycle

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc       <= reset_pc;
      if_valid <= 1'b0;
    end else begin
      if_valid <= fetch_en;
      if (fetch_en) begin
        pc <= pc + pc_step; // pc holds while paused
      end
    end
  end

  // fetch register payload
  always_ff @(posedge clk) begin
    if (fetch_en) begin
      if_pc   <= pc;
      if_inst <= imem_data;
    end else begin
      if_inst <= nop_inst; // bubble
    end
  end

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_isa_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  logic      wb_we,
  input  reg_addr_t wb_addr,
  input  word_t     wb_data
);

  word_t regs [num_regs];
  logic  wr_en;

  assign wr_en = wb_we && (wb_addr != '0); // writes to x0 are dropped

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb_addr] <= wb_data;
    end
  end

  // x0 reads zero, a same-cycle write passes straight through
  function automatic word_t read_port(reg_addr_t addr);
    if (addr == '0) return '0;
    if (wr_en && (wb_addr == addr)) return wb_data;
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n) regs[0] == '0);

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      if_valid,
  input  word_t     if_pc,
  input  inst_t     if_inst,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output logic      id_valid,
  output word_t     id_pc,
  output reg_addr_t id_rd,
  output reg_addr_t id_rs1,
  output reg_addr_t id_rs2,
  output word_t     id_rs1_data,
  output word_t     id_rs2_data,
  output word_t     id_imm,
  output alu_fn_e   id_alu_fn,
  output op_a_sel_e id_op_a_sel,
  output op_b_sel_e id_op_b_sel,
  output logic      id_reg_write
);

  logic [opc_w-1:0]    opcode;
  logic [funct3_w-1:0] funct3;
  logic [funct7_w-1:0] funct7;
  reg_addr_t           rd;
  logic                alt;
  word_t               imm_i;
  word_t               imm_u;
  logic                dec_ok;
  alu_fn_e             alu_fn;
  op_a_sel_e           op_a_sel;
  op_b_sel_e           op_b_sel;
  word_t               imm;

  assign opcode   = if_inst[opc_lsb +: opc_w];
  assign funct3   = if_inst[funct3_lsb +: funct3_w];
  assign funct7   = if_inst[funct7_lsb +: funct7_w];
  assign rd       = if_inst[rd_lsb +: reg_addr_w];
  assign rs1_addr = if_inst[rs1_lsb +: reg_addr_w];
  assign rs2_addr = if_inst[rs2_lsb +: reg_addr_w];
  assign alt      = (funct7 == alt_funct7);

  assign imm_i = {{(xlen - imm_i_w){if_inst[ilen-1]}}, if_inst[imm_i_lsb +: imm_i_w]};
  assign imm_u = {if_inst[imm_u_lsb +: imm_u_w], {(xlen - imm_u_w){1'b0}}};

  // sub exists only in the register form
  // sra and srai share the alt bit
  function automatic alu_fn_e f3_to_alu(logic [funct3_w-1:0] f3, logic alt_bit, logic is_reg);
    case (f3)
      f3_add_sub: return (alt_bit && is_reg) ? alu_sub : alu_add;
      f3_sll:     return alu_sll;
      f3_slt:     return alu_slt;
      f3_sltu:    return alu_sltu;
      f3_xor:     return alu_xor;
      f3_srl_sra: return alt_bit ? alu_sra : alu_srl;
      f3_or:      return alu_or;
      default:    return alu_and;
    endcase
  endfunction

  always_comb begin
    dec_ok   = 1'b1;
    alu_fn   = alu_add;
    op_a_sel = op_a_rs1;
    op_b_sel = op_b_rs2;
    imm      = imm_i;
    case (opcode)
      opc_op: alu_fn = f3_to_alu(funct3, alt, 1'b1);
      opc_op_imm: begin
        alu_fn   = f3_to_alu(funct3, alt, 1'b0);
        op_b_sel = op_b_imm; // shamt sits in the low imm bits
      end
      opc_lui: begin
        op_a_sel = op_a_zero; // 0 + imm_u
        op_b_sel = op_b_imm;
        imm      = imm_u;
      end
      default: begin
        dec_ok   = 1'b0; // unsupported opcode becomes a bubble
        alu_fn   = alu_pass_b;
        op_b_sel = op_b_imm;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_valid     <= 1'b0;
      id_reg_write <= 1'b0;
    end else begin
      id_valid     <= if_valid && dec_ok;
      id_reg_write <= if_valid && dec_ok; // every kept op writes rd
    end
  end

  always_ff @(posedge clk) begin
    id_pc       <= if_pc;
    id_rd       <= rd;
    id_rs1      <= rs1_addr;
    id_rs2      <= rs2_addr;
    id_rs1_data <= rs1_data;
    id_rs2_data <= rs2_data;
    id_imm      <= imm;
    id_alu_fn   <= alu_fn;
    id_op_a_sel <= op_a_sel;
    id_op_b_sel <= op_b_sel;
  end

  // pass_b only marks a dropped opcode
  a_alu_fn_legal: assert property (@(posedge clk) disable iff (!arst_n)
    id_valid |-> id_alu_fn inside {alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
                                   alu_srl, alu_sra, alu_or, alu_and});

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      id_valid,
  input  word_t     id_pc,
  input  reg_addr_t id_rd,
  input  reg_addr_t id_rs1,
  input  reg_addr_t id_rs2,
  input  word_t     id_rs1_data,
  input  word_t     id_rs2_data,
  input  word_t     id_imm,
  input  alu_fn_e   id_alu_fn,
  input  op_a_sel_e id_op_a_sel,
  input  op_b_sel_e id_op_b_sel,
  input  logic      id_reg_write,
  input  logic      wb_we,
  input  reg_addr_t wb_addr,
  input  word_t     wb_data,
  output logic      ex_valid,
  output word_t     ex_pc,
  output reg_addr_t ex_rd,
  output word_t     ex_result,
  output logic      ex_reg_write
);

  localparam int shamt_w = $clog2(xlen);

  word_t              rs1_val;
  word_t              rs2_val;
  word_t              op_a;
  word_t              op_b;
  word_t              alu_out;
  logic [shamt_w-1:0] shamt;

  // writeback bypass, wb_we is already low for x0
  assign rs1_val = (wb_we && (wb_addr == id_rs1)) ? wb_data : id_rs1_data;
  assign rs2_val = (wb_we && (wb_addr == id_rs2)) ? wb_data : id_rs2_data;

  assign op_a  = (id_op_a_sel == op_a_zero) ? '0 : rs1_val;
  assign op_b  = (id_op_b_sel == op_b_imm) ? id_imm : rs2_val;
  assign shamt = op_b[shamt_w-1:0];

  always_comb begin
    case (id_alu_fn)
      alu_add:  alu_out = op_a + op_b;
      alu_sub:  alu_out = op_a - op_b;
      alu_sll:  alu_out = op_a << shamt;
      alu_slt:  alu_out = {{(xlen - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_out = {{(xlen - 1){1'b0}}, op_a < op_b};
      alu_xor:  alu_out = op_a ^ op_b;
      alu_srl:  alu_out = op_a >> shamt;
      alu_sra:  alu_out = $signed(op_a) >>> shamt;
      alu_or:   alu_out = op_a | op_b;
      alu_and:  alu_out = op_a & op_b;
      default:  alu_out = op_b; // pass_b
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid     <= 1'b0;
      ex_reg_write <= 1'b0;
    end else begin
      ex_valid     <= id_valid;
      ex_reg_write <= id_valid && id_reg_write;
    end
  end

  always_ff @(posedge clk) begin
    ex_pc     <= id_pc;
    ex_rd     <= id_rd;
    ex_result <= alu_out;
  end

endmodule

//--- source/writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit import rv_isa_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        ex_valid,
  input  word_t       ex_pc,
  input  reg_addr_t   ex_rd,
  input  word_t       ex_result,
  input  logic        ex_reg_write,
  output logic        wb_we,
  output reg_addr_t   wb_addr,
  output word_t       wb_data,
  output logic        retire_valid,
  output word_t       retire_pc,
  output reg_addr_t   retire_rd,
  output word_t       retire_data,
  output logic [31:0] instret
);

  // no register write for rd = x0
  assign wb_we   = ex_valid && ex_reg_write && (ex_rd != '0);
  assign wb_addr = ex_rd;
  assign wb_data = ex_result;

  // retire trace is a one-cycle strobe per instruction
  assign retire_valid = ex_valid;
  assign retire_pc    = ex_pc;
  assign retire_rd    = ex_rd;
  assign retire_data  = ex_result;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      instret <= '0;
    end else if (retire_valid) begin
      instret <= instret + 32'd1;
    end
  end

  // every register write is also a retirement
  a_we_retires: assert property (@(posedge clk) disable iff (!arst_n)
    wb_we |-> retire_valid);

endmodule

//--- source/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        fetch_en,
  output word_t       imem_addr,
  input  inst_t       imem_data,
  output logic        retire_valid,
  output word_t       retire_pc,
  output reg_addr_t   retire_rd,
  output word_t       retire_data,
  output logic [31:0] instret
);

  // fetch to decode
  logic      if_valid;
  word_t     if_pc;
  inst_t     if_inst;
  // register file read ports
  reg_addr_t rs1_addr, rs2_addr;
  word_t     rs1_data, rs2_data;
  // decode to execute
  logic      id_valid, id_reg_write;
  word_t     id_pc, id_rs1_data, id_rs2_data, id_imm;
  reg_addr_t id_rd, id_rs1, id_rs2;
  alu_fn_e   id_alu_fn;
  op_a_sel_e id_op_a_sel;
  op_b_sel_e id_op_b_sel;
  // execute to writeback
  logic      ex_valid, ex_reg_write;
  word_t     ex_pc, ex_result;
  reg_addr_t ex_rd;
  // write request, also the forwarding source
  logic      wb_we;
  reg_addr_t wb_addr;
  word_t     wb_data;

  fetch_unit     i_fetch_unit     (.*);
  decode_stage   i_decode_stage   (.*);
  reg_file       i_reg_file       (.*);
  execute_stage  i_execute_stage  (.*);
  writeback_unit i_writeback_unit (.*);

endmodule

//--- sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import rv_isa_pkg::*; ();

  localparam int prog_len    = 96;
  localparam int chain_len   = 12;
  localparam int issue_limit = 4 * prog_len;
  localparam int drain_limit = 20;

  logic        clk;
  logic        arst_n;
  logic        fetch_en;
  word_t       imem_addr;
  inst_t       imem_data;
  logic        retire_valid;
  word_t       retire_pc;
  reg_addr_t   retire_rd;
  word_t       retire_data;
  logic [31:0] instret;

  inst_t       prog [prog_len];
  int          prog_n;
  word_t       gold [num_regs]; // reference register file
  logic [31:0] lfsr;
  word_t       fetch_cnt;       // fetches seen at rising edges
  word_t       seen_cnt;        // retire strobes seen at rising edges
  int          ret_idx;         // next program index to retire
  word_t       exp_pc;
  reg_addr_t   exp_rd;
  word_t       exp_data;
  word_t       exp_addr;

  rv_core i_rv_core (
    .clk          (clk),
    .arst_n       (arst_n),
    .fetch_en     (fetch_en),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .instret      (instret)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic value_error(input string sig, input logic [31:0] exp, input logic [31:0] act);
    stop_run($sformatf("CHECK FAILED %s expected %h actual %h", sig, exp, act));
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic next_rand_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_rand_bit()};
    end
    return v;
  endfunction

  function automatic inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc_op_imm};
  endfunction

  function automatic inst_t enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, opc_lui};
  endfunction

  // random kept op on x0..x7
  function automatic inst_t random_inst();
    logic [31:0] r;
    logic [31:0] u;
    logic [11:0] imm;
    logic        alt;
    r   = rand_bits(28);
    imm = r[27:16];
    alt = r[15];
    if (r[2:0] == 3'd7) begin
      u = rand_bits(20);
      return enc_u(u[19:0], {2'b00, r[8:6]});
    end
    if (r[2:0] < 3'd4) begin
      if (r[5:3] != f3_add_sub && r[5:3] != f3_srl_sra) alt = 1'b0; // no alt form
      return enc_r(alt ? alt_funct7 : 7'h00, {2'b00, r[14:12]}, {2'b00, r[11:9]}, r[5:3],
                   {2'b00, r[8:6]});
    end
    if (r[5:3] == f3_sll) imm = {7'h00, imm[4:0]};
    if (r[5:3] == f3_srl_sra) imm = {alt ? alt_funct7 : 7'h00, imm[4:0]};
    return enc_i(imm, {2'b00, r[11:9]}, r[5:3], {2'b00, r[8:6]});
  endfunction

  // result of one instruction by the isa rules
  function automatic word_t ref_result(input inst_t inst, input word_t r1, input word_t r2);
    word_t      b;
    logic [4:0] sh;
    logic       is_reg;
    if (inst[6:0] == opc_lui) return {inst[31:12], 12'h000};
    is_reg = (inst[6:0] == opc_op);
    b      = is_reg ? r2 : {{20{inst[31]}}, inst[31:20]};
    sh     = b[4:0];
    case (inst[14:12])
      f3_add_sub: return (is_reg && inst[30]) ? r1 - b : r1 + b;
      f3_sll:     return r1 << sh;
      f3_slt:     return ($signed(r1) < $signed(b)) ? 32'd1 : 32'd0;
      f3_sltu:    return (r1 < b) ? 32'd1 : 32'd0;
      f3_xor:     return r1 ^ b;
      f3_srl_sra: return inst[30] ? word_t'($signed(r1) >>> sh) : r1 >> sh;
      f3_or:      return r1 | b;
      default:    return r1 & b;
    endcase
  endfunction

  function automatic inst_t word_at(input int idx);
    if (idx >= 0 && idx < prog_len) return prog[idx];
    return nop_inst;
  endfunction

  task automatic add_inst(input inst_t w);
    prog[prog_n] = w;
    prog_n++;
  endtask

  // memory model answers the current address
  always @(negedge clk) begin
    imem_data = word_at(int'(imem_addr / pc_step));
  end

  // expected retire values, reference registers follow program order
  always @(negedge clk) begin : expect_retire
    inst_t inst;
    if (arst_n && retire_valid) begin
      inst     = word_at(ret_idx);
      exp_pc   = reset_pc + pc_step * ret_idx;
      exp_rd   = inst[11:7];
      exp_data = ref_result(inst, gold[inst[19:15]], gold[inst[24:20]]);
      if (exp_rd != '0) gold[exp_rd] = exp_data; // x0 stays zero
      ret_idx  = ret_idx + 1;
    end
  end

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_cnt <= '0;
      seen_cnt  <= '0;
    end else begin
      if (fetch_en) fetch_cnt <= fetch_cnt + 1;
      if (retire_valid) seen_cnt <= seen_cnt + 1;
    end
  end

  assign exp_addr = reset_pc + pc_step * fetch_cnt;

  a_rst_retire: assert property (@(posedge clk) !arst_n |-> !retire_valid)
    else value_error("retire_valid", 32'h0, {31'h0, $sampled(retire_valid)});
  a_rst_addr: assert property (@(posedge clk) !arst_n |-> imem_addr == reset_pc)
    else value_error("imem_addr", reset_pc, $sampled(imem_addr));
  a_rst_instret: assert property (@(posedge clk) !arst_n |-> instret == '0)
    else value_error("instret", 32'h0, $sampled(instret));

  a_fetch_addr: assert property (@(posedge clk) disable iff (!arst_n) imem_addr == exp_addr)
    else value_error("imem_addr", exp_addr, $sampled(imem_addr));
  a_ret_pc: assert property (@(posedge clk) disable iff (!arst_n)
    retire_valid |-> retire_pc == exp_pc)
    else value_error("retire_pc", exp_pc, $sampled(retire_pc));
  a_ret_rd: assert property (@(posedge clk) disable iff (!arst_n)
    retire_valid |-> retire_rd == exp_rd)
    else value_error("retire_rd", {27'h0, exp_rd}, {27'h0, $sampled(retire_rd)});
  a_ret_data: assert property (@(posedge clk) disable iff (!arst_n)
    retire_valid |-> retire_data == exp_data)
    else value_error("retire_data", exp_data, $sampled(retire_data));
  a_no_extra_retire: assert property (@(posedge clk) disable iff (!arst_n)
    retire_valid |-> ret_idx <= fetch_cnt)
    else stop_run("a retire strobe appeared with no fetched instruction left to retire");
  a_instret: assert property (@(posedge clk) disable iff (!arst_n) instret == seen_cnt)
    else value_error("instret", seen_cnt, $sampled(instret));

  initial begin : run
    int          issued;
    int          guard;
    logic [31:0] r;
    arst_n    = 1'b1;
    fetch_en  = 1'b0;
    imem_data = nop_inst;
    lfsr      = 32'ha623_421f;
    ret_idx   = 0;
    prog_n    = 0;
    for (int i = 0; i < num_regs; i++) begin
      gold[i] = '0;
    end
    // back to back dependency chain
    add_inst(enc_u(20'h12345, 5'd1));                       // lui x1
    add_inst(enc_i(12'h678, 5'd1, f3_add_sub, 5'd1));       // addi x1, x1
    add_inst(enc_i(12'h003, 5'd1, f3_sll, 5'd2));           // slli x2, x1
    add_inst(enc_r(7'h00, 5'd1, 5'd2, f3_xor, 5'd3));       // xor x3, x2, x1
    add_inst(enc_r(alt_funct7, 5'd2, 5'd3, f3_add_sub, 5'd4));
    add_inst(enc_r(alt_funct7, 5'd1, 5'd4, f3_srl_sra, 5'd5));
    add_inst(enc_r(7'h00, 5'd4, 5'd5, f3_sltu, 5'd6));
    add_inst(enc_r(7'h00, 5'd5, 5'd6, f3_add_sub, 5'd0));   // add x0 is dropped
    add_inst(enc_r(7'h00, 5'd6, 5'd0, f3_or, 5'd7));        // reads x0 right after
    add_inst(enc_i(12'h401, 5'd7, f3_srl_sra, 5'd7));       // srai x7, x7, 1
    add_inst(enc_i(12'hfff, 5'd7, f3_slt, 5'd1));
    add_inst(enc_i(12'h800, 5'd1, f3_xor, 5'd2));
    while (prog_n < prog_len) begin
      add_inst(random_inst());
    end

    #1 arst_n = 1'b0; // clean falling edge
    repeat (5) @(negedge clk);
    arst_n = 1'b1;

    // issue the program, random pauses after the chain
    issued = 0;
    guard  = 0;
    while (issued < prog_len && guard < issue_limit) begin
      @(negedge clk);
      guard++;
      r = rand_bits(3);
      if (issued >= chain_len && r[2:0] == 3'd0) begin
        fetch_en = 1'b0;
      end else begin
        fetch_en = 1'b1;
        issued++;
      end
    end
    @(negedge clk);
    fetch_en = 1'b0;
    if (issued < prog_len) stop_run("timeout while issuing the program");

    guard = 0;
    while (ret_idx < prog_len && guard < drain_limit) begin
      @(posedge clk);
      guard++;
    end
    repeat (8) @(posedge clk); // idle, no retire may show up
    if (ret_idx != prog_len) begin
      stop_run("timeout waiting for the pipeline to drain");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule

//--- files.f
source/rv_isa_pkg.sv
source/core_ctrl_pkg.sv
source/fetch_unit.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/writeback_unit.sv
source/rv_core.sv
sim/tb_rv_core.sv
